//--- rtl/csr_bus_pkg.sv
// CSR bus protocol package
// Command kinds, command and response payloads, bus field widths
package csr_bus_pkg;

  // --------------------
  // Field widths
  // --------------------
  localparam int ID_WIDTH   = 4;
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;

  // --------------------
  // Command kinds
  // --------------------
  typedef enum logic [1:0] {
    CMD_READ         = 2'd0,
    CMD_WRITE        = 2'd1,
    CMD_POSTED_WRITE = 2'd2
  } csr_cmd_kind_e;

  // --------------------
  // Payloads
  // --------------------
  // Write data rides in the command, no separate data channel
  typedef struct packed {
    csr_cmd_kind_e         kind;
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } csr_cmd_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic                  error;
    logic [DATA_WIDTH-1:0] data;
  } csr_resp_t;

  // Posted writes never get a response
  function automatic logic csr_is_posted(csr_cmd_t cmd);
    return cmd.kind == CMD_POSTED_WRITE;
  endfunction

endpackage

//--- rtl/csr_map_pkg.sv
// CSR target address map
// Region codes in the top two address bits, reply delays, register count
package csr_map_pkg;

  // Region codes, code 3 is unmapped
  localparam logic [1:0] REGION_FAST = 2'd0;
  localparam logic [1:0] REGION_SLOW = 2'd1;
  localparam logic [1:0] REGION_DEAD = 2'd2;

  // Reply delay in cycles
  localparam logic [3:0] FAST_DELAY = 4'd2;
  localparam logic [3:0] SLOW_DELAY = 4'd7;

  // Same registers appear in the fast and the slow region
  localparam int REG_WORDS = 16;

endpackage

//--- rtl/csr_slice.sv
// One-stage valid/accept register slice
// Serves any payload type, a pass-through when disabled
`timescale 1ns/1ps

module csr_slice #(
  parameter type T      = logic,
  parameter bit  ENABLE = 1'b1
)(
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_valid,
  output logic o_accept,
  input  T     i_data,
  output logic o_valid,
  input  logic i_accept,
  output T     o_data
);

  if (ENABLE) begin : g_slice
    logic valid_q;
    T     data_q;

    // Takes a new beat when empty or when the held beat leaves
    assign o_accept = !valid_q || i_accept;
    assign o_valid  = valid_q;
    assign o_data   = data_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        valid_q <= 1'b0;
      end else if (o_accept) begin
        valid_q <= i_valid;
      end
    end

    always_ff @(posedge i_clk) begin
      if (i_valid && o_accept) begin
        data_q <= i_data;
      end
    end
  end else begin : g_bypass
    assign o_accept = i_accept;
    assign o_valid  = i_valid;
    assign o_data   = i_data;
  end

  // Held beat must not change under back-pressure
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_valid && !i_accept) |=> (o_valid && $stable(o_data)));

endmodule

//--- rtl/csr_response_reorder.sv
// CSR response reorder buffer
// Retags commands with slot ids and returns responses in command order
`timescale 1ns/1ps

module csr_response_reorder
  import csr_bus_pkg::*;
#(
  parameter int                    ENTRIES       = 4,
  parameter int                    TIMEOUT_WIDTH = 16,
  parameter logic [DATA_WIDTH-1:0] ERROR_DATA    = 32'hdead_aaaa,
  parameter bit                    REQ_SLICE     = 1'b0,
  parameter bit                    TGT_SLICE     = 1'b0
)(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic [ID_WIDTH-1:0]      i_base_id,
  input  logic                     i_timeout_enable,
  input  logic [TIMEOUT_WIDTH-1:0] i_timeout_cycle,
  input  logic                     i_cmd_valid,
  output logic                     o_cmd_accept,
  input  csr_cmd_t                 i_cmd,
  output logic                     o_resp_valid,
  input  logic                     i_resp_accept,
  output csr_resp_t                o_resp,
  output logic                     o_tgt_cmd_valid,
  input  logic                     i_tgt_cmd_accept,
  output csr_cmd_t                 o_tgt_cmd,
  input  logic                     i_tgt_resp_valid,
  input  csr_resp_t                i_tgt_resp
);
  localparam int INDEX_WIDTH = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  typedef struct packed {
    logic                  busy;
    logic                  done;
    logic [ID_WIDTH-1:0]   id;
    logic                  error;
    logic [DATA_WIDTH-1:0] data;
  } slot_t;

  logic                     req_cmd_valid;
  logic                     req_cmd_accept;
  csr_cmd_t                 req_cmd;
  logic                     req_resp_valid;
  logic                     req_resp_accept;
  csr_resp_t                req_resp;
  logic                     tgt_cmd_valid;
  logic                     tgt_cmd_accept;
  csr_cmd_t                 tgt_cmd;
  logic                     tgt_resp_valid;
  csr_resp_t                tgt_resp;
  logic [INDEX_WIDTH-1:0]   req_ptr;
  logic [INDEX_WIDTH-1:0]   rsp_ptr;
  logic [INDEX_WIDTH-1:0]   tgt_resp_idx;
  slot_t                    slots [ENTRIES];
  logic [ENTRIES-1:0]       slot_busy;
  logic [ENTRIES-1:0]       slot_waiting;
  logic                     cmd_np_ack;
  logic                     resp_ack;
  logic                     pass;
  logic                     timeout;
  logic [TIMEOUT_WIDTH-1:0] timeout_count;

  // --------------------
  // Requester side
  // --------------------
  csr_slice #(.T(csr_cmd_t), .ENABLE(REQ_SLICE)) u_req_cmd_slice (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_cmd_valid),
    .o_accept (o_cmd_accept),
    .i_data   (i_cmd),
    .o_valid  (req_cmd_valid),
    .i_accept (req_cmd_accept),
    .o_data   (req_cmd)
  );

  csr_slice #(.T(csr_resp_t), .ENABLE(REQ_SLICE)) u_req_resp_slice (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (req_resp_valid),
    .o_accept (req_resp_accept),
    .i_data   (req_resp),
    .o_valid  (o_resp_valid),
    .i_accept (i_resp_accept),
    .o_data   (o_resp)
  );

  // Posted writes bypass the slot check
  always_comb begin
    pass           = csr_is_posted(req_cmd) || !slot_busy[req_ptr];
    tgt_cmd_valid  = req_cmd_valid && pass;
    req_cmd_accept = tgt_cmd_accept && pass;
    tgt_cmd        = req_cmd;
    tgt_cmd.id     = i_base_id | ID_WIDTH'(req_ptr);
  end

  assign cmd_np_ack = req_cmd_valid && req_cmd_accept && !csr_is_posted(req_cmd);
  assign resp_ack   = req_resp_valid && req_resp_accept;

  // Head slot drives the response directly
  always_comb begin
    req_resp_valid = slots[rsp_ptr].busy && slots[rsp_ptr].done;
    req_resp.id    = slots[rsp_ptr].id;
    req_resp.error = slots[rsp_ptr].error;
    req_resp.data  = slots[rsp_ptr].error ? ERROR_DATA : slots[rsp_ptr].data;
  end

  // --------------------
  // Slot ring
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      req_ptr <= '0;
    end else if (cmd_np_ack) begin
      req_ptr <= (req_ptr == INDEX_WIDTH'(ENTRIES - 1)) ? '0 : req_ptr + 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rsp_ptr <= '0;
    end else if (resp_ack) begin
      rsp_ptr <= (rsp_ptr == INDEX_WIDTH'(ENTRIES - 1)) ? '0 : rsp_ptr + 1'b1;
    end
  end

  // Low id bits name the slot
  assign tgt_resp_idx = INDEX_WIDTH'(tgt_resp.id);

  for (genvar i = 0; i < ENTRIES; i++) begin : g_slot
    logic init;
    logic update;
    logic clear;

    assign init            = cmd_np_ack && (req_ptr == INDEX_WIDTH'(i));
    assign update          = tgt_resp_valid && (tgt_resp_idx == INDEX_WIDTH'(i));
    assign clear           = resp_ack && (rsp_ptr == INDEX_WIDTH'(i));
    assign slot_busy[i]    = slots[i].busy;
    assign slot_waiting[i] = slots[i].busy && !slots[i].done;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        slots[i].busy <= 1'b0;
        slots[i].done <= 1'b0;
      end else if (init) begin
        slots[i].busy <= 1'b1;
        slots[i].done <= 1'b0;
        slots[i].id   <= req_cmd.id;
      end else if (slot_waiting[i] && (update || timeout)) begin
        slots[i].done  <= 1'b1;
        slots[i].error <= tgt_resp.error || timeout;
        slots[i].data  <= tgt_resp.data;
      end else if (clear) begin
        slots[i].busy <= 1'b0;
        slots[i].done <= 1'b0;
      end
    end
  end

  // --------------------
  // Timeout
  // --------------------
  assign timeout = i_timeout_enable && (timeout_count == i_timeout_cycle);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      timeout_count <= '0;
    end else if (cmd_np_ack) begin
      timeout_count <= '0;
    end else if (slot_waiting != '0) begin
      timeout_count <= timeout_count + 1'b1;
    end
  end

  // --------------------
  // Target side
  // --------------------
  csr_slice #(.T(csr_cmd_t), .ENABLE(TGT_SLICE)) u_tgt_cmd_slice (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (tgt_cmd_valid),
    .o_accept (tgt_cmd_accept),
    .i_data   (tgt_cmd),
    .o_valid  (o_tgt_cmd_valid),
    .i_accept (i_tgt_cmd_accept),
    .o_data   (o_tgt_cmd)
  );

  // Responses are always taken, target has no accept input
  csr_slice #(.T(csr_resp_t), .ENABLE(TGT_SLICE)) u_tgt_resp_slice (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_tgt_resp_valid),
    .o_accept (),
    .i_data   (i_tgt_resp),
    .o_valid  (tgt_resp_valid),
    .i_accept (1'b1),
    .o_data   (tgt_resp)
  );

  // Target only answers ids handed out by this ring
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    tgt_resp_valid |-> slot_busy[tgt_resp_idx]);

  // Request pointer sits on a busy slot only when the ring is full
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    slot_busy[req_ptr] |-> ((&slot_busy) && (req_ptr == rsp_ptr)));

endmodule

//--- rtl/csr_target_bank.sv
// CSR register bank target
// Region-dependent reply delay, replies leave from a table of pending slots
`timescale 1ns/1ps

module csr_target_bank
  import csr_bus_pkg::*;
  import csr_map_pkg::*;
#(
  parameter int TARGET_SLOTS = 4
)(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_cmd_valid,
  output logic      o_cmd_accept,
  input  csr_cmd_t  i_cmd,
  output logic      o_resp_valid,
  output csr_resp_t o_resp
);
  localparam int SLOT_WIDTH = (TARGET_SLOTS > 1) ? $clog2(TARGET_SLOTS) : 1;
  localparam int REG_INDEX_WIDTH = $clog2(REG_WORDS);

  typedef struct packed {
    logic       valid;
    logic [3:0] count;
    csr_resp_t  resp;
  } pending_t;

  logic [DATA_WIDTH-1:0]      regs [REG_WORDS];
  pending_t                   pend [TARGET_SLOTS];
  logic [TARGET_SLOTS-1:0]    slot_busy;
  logic [TARGET_SLOTS-1:0]    slot_ready;
  logic [1:0]                 region;
  logic [REG_INDEX_WIDTH-1:0] reg_index;
  logic                       mapped;
  logic                       is_dead;
  logic                       is_posted;
  logic                       have_free;
  logic [SLOT_WIDTH-1:0]      free_idx;
  logic [SLOT_WIDTH-1:0]      reply_idx;
  logic                       cmd_ack;
  logic                       load;
  csr_resp_t                  new_resp;
  logic [3:0]                 new_delay;

  // --------------------
  // Decode
  // --------------------
  always_comb begin
    region    = i_cmd.addr[ADDR_WIDTH-1 -: 2];
    reg_index = i_cmd.addr[REG_INDEX_WIDTH-1:0];
    mapped    = (region == REGION_FAST) || (region == REGION_SLOW);
    is_dead   = (region == REGION_DEAD);
    is_posted = csr_is_posted(i_cmd);
  end

  // Lowest free slot
  always_comb begin
    have_free = 1'b0;
    free_idx  = '0;
    for (int i = TARGET_SLOTS - 1; i >= 0; i--) begin
      if (!slot_busy[i]) begin
        have_free = 1'b1;
        free_idx  = SLOT_WIDTH'(i);
      end
    end
  end

  // Posted and dead-region commands never take a slot
  assign o_cmd_accept = is_posted || is_dead || have_free;
  assign cmd_ack      = i_cmd_valid && o_cmd_accept;
  assign load         = cmd_ack && !is_posted && !is_dead;

  // Reply formed at acceptance, read data captured now
  always_comb begin
    new_resp.id    = i_cmd.id;
    new_resp.error = !mapped;
    new_resp.data  = (mapped && (i_cmd.kind == CMD_READ)) ? regs[reg_index] : '0;
    new_delay      = (region == REGION_SLOW) ? SLOW_DELAY : FAST_DELAY;
  end

  // --------------------
  // Register file
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (cmd_ack && mapped && (i_cmd.kind != CMD_READ)) begin
      regs[reg_index] <= i_cmd.data;
    end
  end

  // --------------------
  // Pending replies
  // --------------------
  for (genvar i = 0; i < TARGET_SLOTS; i++) begin : g_pend
    assign slot_busy[i]  = pend[i].valid;
    assign slot_ready[i] = pend[i].valid && (pend[i].count == 4'd0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        pend[i].valid <= 1'b0;
        pend[i].count <= 4'd0;
      end else if (load && (free_idx == SLOT_WIDTH'(i))) begin
        pend[i].valid <= 1'b1;
        pend[i].count <= new_delay;
        pend[i].resp  <= new_resp;
      end else if (pend[i].count != 4'd0) begin
        pend[i].count <= pend[i].count - 4'd1;
      end else if (o_resp_valid && (reply_idx == SLOT_WIDTH'(i))) begin
        pend[i].valid <= 1'b0;
      end
    end
  end

  // One reply per cycle, lowest ready slot first
  always_comb begin
    reply_idx = '0;
    for (int i = TARGET_SLOTS - 1; i >= 0; i--) begin
      if (slot_ready[i]) begin
        reply_idx = SLOT_WIDTH'(i);
      end
    end
    o_resp_valid = slot_ready != '0;
    o_resp       = pend[reply_idx].resp;
  end

  // Replying slot is released, so no reply leaves an emptied slot
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_resp_valid |=> !slot_busy[$past(reply_idx)]);

endmodule

//--- rtl/csr_reorder_top.sv
// CSR reorder subsystem top level
// Reorder buffer in front of a region-latency register bank
`timescale 1ns/1ps

module csr_reorder_top
  import csr_bus_pkg::*;
#(
  parameter int                    ENTRIES       = 4,
  parameter int                    TIMEOUT_WIDTH = 16,
  parameter logic [DATA_WIDTH-1:0] ERROR_DATA    = 32'hdead_aaaa,
  parameter bit                    REQ_SLICE     = 1'b0,
  parameter bit                    TGT_SLICE     = 1'b0,
  parameter int                    TARGET_SLOTS  = 4
)(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic [ID_WIDTH-1:0]      i_base_id,
  input  logic                     i_timeout_enable,
  input  logic [TIMEOUT_WIDTH-1:0] i_timeout_cycle,
  input  logic                     i_cmd_valid,
  output logic                     o_cmd_accept,
  input  csr_cmd_t                 i_cmd,
  output logic                     o_resp_valid,
  input  logic                     i_resp_accept,
  output csr_resp_t                o_resp
);
  logic      tgt_cmd_valid;
  logic      tgt_cmd_accept;
  csr_cmd_t  tgt_cmd;
  logic      tgt_resp_valid;
  csr_resp_t tgt_resp;

  csr_response_reorder #(
    .ENTRIES       (ENTRIES),
    .TIMEOUT_WIDTH (TIMEOUT_WIDTH),
    .ERROR_DATA    (ERROR_DATA),
    .REQ_SLICE     (REQ_SLICE),
    .TGT_SLICE     (TGT_SLICE)
  ) u_reorder (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_base_id        (i_base_id),
    .i_timeout_enable (i_timeout_enable),
    .i_timeout_cycle  (i_timeout_cycle),
    .i_cmd_valid      (i_cmd_valid),
    .o_cmd_accept     (o_cmd_accept),
    .i_cmd            (i_cmd),
    .o_resp_valid     (o_resp_valid),
    .i_resp_accept    (i_resp_accept),
    .o_resp           (o_resp),
    .o_tgt_cmd_valid  (tgt_cmd_valid),
    .i_tgt_cmd_accept (tgt_cmd_accept),
    .o_tgt_cmd        (tgt_cmd),
    .i_tgt_resp_valid (tgt_resp_valid),
    .i_tgt_resp       (tgt_resp)
  );

  csr_target_bank #(
    .TARGET_SLOTS (TARGET_SLOTS)
  ) u_target (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_valid  (tgt_cmd_valid),
    .o_cmd_accept (tgt_cmd_accept),
    .i_cmd        (tgt_cmd),
    .o_resp_valid (tgt_resp_valid),
    .o_resp       (tgt_resp)
  );

endmodule

//--- testbench/tb_csr_reorder.sv
// Testbench for the CSR reorder subsystem
// Random commands against a reference model, responses checked by assertions
`timescale 1ns/1ps

module tb_csr_reorder
  import csr_bus_pkg::*;
  import csr_map_pkg::*;
();
  localparam logic [DATA_WIDTH-1:0] ERROR_DATA      = 32'hdead_aaaa;
  localparam logic [1:0]            REGION_UNMAPPED = 2'd3;
  localparam int                    CMD_LIMIT       = 200;
  localparam int                    DRAIN_LIMIT     = 400;

  logic                  i_clk;
  logic                  i_rst_n;
  logic [ID_WIDTH-1:0]   i_base_id;
  logic                  i_timeout_enable;
  logic [15:0]           i_timeout_cycle;
  logic                  i_cmd_valid;
  csr_cmd_t              i_cmd;
  logic                  i_resp_accept;
  logic                  o_cmd_accept;
  logic                  o_resp_valid;
  csr_resp_t             o_resp;

  logic [DATA_WIDTH-1:0] model_regs [REG_WORDS];
  csr_resp_t             exp_q [$];
  csr_resp_t             exp_head;
  logic                  exp_have;
  logic                  resp_fire;
  bit                    bp_random = 1'b0;
  bit                    aborted = 1'b0;
  int                    fail_count = 0;
  int                    resp_count = 0;
  int                    np_count = 0;
  int                    cmd_count = 0;
  int                    test_cmds;
  int                    test_np;
  int                    test_resp;

  csr_reorder_top #(
    .ENTRIES       (4),
    .TIMEOUT_WIDTH (16),
    .ERROR_DATA    (ERROR_DATA),
    .REQ_SLICE     (1'b1),
    .TGT_SLICE     (1'b1),
    .TARGET_SLOTS  (4)
  ) dut0 (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_base_id        (i_base_id),
    .i_timeout_enable (i_timeout_enable),
    .i_timeout_cycle  (i_timeout_cycle),
    .i_cmd_valid      (i_cmd_valid),
    .o_cmd_accept     (o_cmd_accept),
    .i_cmd            (i_cmd),
    .o_resp_valid     (o_resp_valid),
    .i_resp_accept    (i_resp_accept),
    .o_resp           (o_resp)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // Random back-pressure on the response channel
  task automatic drive_backpressure();
    forever begin
      @(negedge i_clk);
      i_resp_accept = bp_random ? 1'($urandom) : 1'b1;
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic void flag_value(input string name, input logic [31:0] got,
                                     input logic [31:0] want);
    fail_count++;
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
  endfunction

  function automatic void flag_event(input string what);
    fail_count++;
    $display("ERROR at %0t: %s", $time, what);
  endfunction

  function automatic void refresh_head();
    exp_have = exp_q.size() != 0;
    if (exp_have) begin
      exp_head = exp_q[0];
    end
  endfunction

  function automatic void model_cmd(input csr_cmd_t c);
    logic [1:0] region;
    logic       mapped;
    csr_resp_t  r;
    region = c.addr[ADDR_WIDTH-1 -: 2];
    mapped = (region == REGION_FAST) || (region == REGION_SLOW);
    cmd_count++;
    if (c.kind != CMD_POSTED_WRITE) begin
      np_count++;
      r.id    = c.id;
      r.error = !mapped;
      if (!mapped) begin
        r.data = ERROR_DATA;
      end else if (c.kind == CMD_READ) begin
        r.data = model_regs[c.addr[3:0]];
      end else begin
        r.data = '0;
      end
      // Dead region only answers through the timeout
      if (region != REGION_DEAD || i_timeout_enable) begin
        exp_q.push_back(r);
      end
    end
    if (mapped && c.kind != CMD_READ) begin
      model_regs[c.addr[3:0]] = c.data;
    end
    refresh_head();
  endfunction

  assign resp_fire = o_resp_valid && i_resp_accept;

  always @(posedge i_clk) begin
    if (i_rst_n && resp_fire) begin
      resp_count++;
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      refresh_head();
    end
  end

  // --------------------
  // Response checks
  // --------------------
  assert property (@(posedge i_clk) disable iff (!i_rst_n) resp_fire |-> exp_have)
    else flag_event("response arrived while none was expected");

  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (resp_fire && exp_have) |-> (o_resp.id == exp_head.id))
    else flag_value("o_resp.id", $sampled(o_resp.id), $sampled(exp_head.id));

  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (resp_fire && exp_have) |-> (o_resp.error == exp_head.error))
    else flag_value("o_resp.error", $sampled(o_resp.error), $sampled(exp_head.error));

  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (resp_fire && exp_have) |-> (o_resp.data == exp_head.data))
    else flag_value("o_resp.data", $sampled(o_resp.data), $sampled(exp_head.data));

  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_resp_valid && !i_resp_accept) |=> (o_resp_valid && $stable(o_resp)))
    else flag_event("o_resp changed or dropped while held under back-pressure");

  // --------------------
  // Stimulus helpers
  // --------------------
  function automatic logic [1:0] rand_mapped();
    return ($urandom_range(0, 1) == 0) ? REGION_FAST : REGION_SLOW;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] pick_addr(input logic [1:0] region);
    return {region, 2'b00, 4'($urandom)};
  endfunction

  // Leaves valid high so commands can go back to back
  task automatic send_cmd(input csr_cmd_kind_e kind, input logic [ADDR_WIDTH-1:0] addr);
    csr_cmd_t c;
    int       cycles;
    if (aborted) return;
    c.kind = kind;
    c.id   = ID_WIDTH'($urandom);
    c.addr = addr;
    c.data = $urandom;
    @(negedge i_clk);
    i_cmd_valid = 1'b1;
    i_cmd       = c;
    cycles      = 0;
    do begin
      @(posedge i_clk);
      cycles++;
    end while (!o_cmd_accept && cycles < CMD_LIMIT);
    if (o_cmd_accept) begin
      model_cmd(c);
    end else begin
      flag_event("command was not accepted within the cycle limit");
      aborted = 1'b1;
    end
  endtask

  task automatic stop_cmds();
    @(negedge i_clk);
    i_cmd_valid = 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    while (!aborted && exp_q.size() != 0 && cycles < limit) begin
      @(negedge i_clk);
      cycles++;
    end
    if (!aborted && exp_q.size() != 0) begin
      flag_event($sformatf("%0d responses still missing after %0d cycles",
                           exp_q.size(), limit));
      aborted = 1'b1;
    end
  endtask

  task automatic start_test();
    test_cmds = cmd_count;
    test_np   = np_count;
    test_resp = resp_count;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d commands, %0d responses, %0d failures so far",
             num, name, cmd_count - test_cmds, resp_count - test_resp, fail_count);
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic order_test();
    start_test();
    repeat (12) send_cmd(CMD_READ, pick_addr(rand_mapped()));
    stop_cmds();
    wait_drain(DRAIN_LIMIT);
    end_test(1, "mixed fast and slow reads");
  endtask

  task automatic read_data_test();
    start_test();
    // Both write kinds, alternating
    for (int i = 0; i < 8; i++) begin
      send_cmd((i % 2 == 0) ? CMD_WRITE : CMD_POSTED_WRITE,
               pick_addr(rand_mapped()));
    end
    for (int i = 0; i < REG_WORDS; i++) begin
      send_cmd(CMD_READ, {rand_mapped(), 2'b00, 4'(i)});
    end
    stop_cmds();
    wait_drain(DRAIN_LIMIT);
    end_test(2, "read data after writes");
  endtask

  task automatic posted_test();
    start_test();
    repeat (4) send_cmd(CMD_READ, pick_addr(REGION_SLOW));
    repeat (2) send_cmd(CMD_POSTED_WRITE, pick_addr(rand_mapped()));
    stop_cmds();
    // Slow reads still hold every slot here
    assert (resp_count == test_resp)
      else flag_value("responses before posted writes", resp_count - test_resp, 0);
    send_cmd(CMD_READ, pick_addr(REGION_SLOW));
    send_cmd(CMD_READ, pick_addr(rand_mapped()));
    stop_cmds();
    wait_drain(DRAIN_LIMIT);
    assert (resp_count - test_resp == np_count - test_np)
      else flag_value("response count", resp_count - test_resp, np_count - test_np);
    end_test(3, "posted writes while slots busy");
  endtask

  task automatic unmapped_test();
    start_test();
    send_cmd(CMD_READ, pick_addr(REGION_FAST));
    send_cmd(CMD_READ, pick_addr(REGION_UNMAPPED));
    send_cmd(CMD_READ, pick_addr(REGION_SLOW));
    send_cmd(CMD_WRITE, pick_addr(REGION_UNMAPPED));
    send_cmd(CMD_READ, pick_addr(REGION_FAST));
    stop_cmds();
    wait_drain(DRAIN_LIMIT);
    end_test(4, "unmapped addresses");
  endtask

  task automatic backpressure_test();
    logic [1:0] region;
    start_test();
    @(posedge i_clk);
    bp_random = 1'b1;
    for (int i = 0; i < 24; i++) begin
      region = ($urandom_range(0, 3) == 0) ? REGION_UNMAPPED : rand_mapped();
      send_cmd(csr_cmd_kind_e'($urandom_range(0, 2)), pick_addr(region));
    end
    stop_cmds();
    wait_drain(DRAIN_LIMIT);
    @(posedge i_clk);
    bp_random = 1'b0;
    end_test(5, "random back-pressure");
  endtask

  task automatic timeout_test();
    int cycles;
    start_test();
    @(negedge i_clk);
    i_timeout_cycle  = 16'd20;
    i_timeout_enable = 1'b1;
    send_cmd(CMD_READ, pick_addr(REGION_DEAD));
    stop_cmds();
    wait_drain(DRAIN_LIMIT);
    end_test(6, "dead read with timeout");
    // Without the timeout the dead read never completes
    start_test();
    @(negedge i_clk);
    i_timeout_enable = 1'b0;
    send_cmd(CMD_READ, pick_addr(REGION_DEAD));
    stop_cmds();
    cycles = 0;
    while (!aborted && resp_count == test_resp && cycles < 100) begin
      @(negedge i_clk);
      cycles++;
    end
    assert (resp_count == test_resp)
      $display("test 6 dead read without timeout: no response in %0d cycles, as expected",
               cycles);
    else
      flag_value("responses from dead read", resp_count - test_resp, 0);
  endtask

  initial begin
    void'($urandom(32'h24ab_7033));
    i_rst_n          = 1'b0;
    i_base_id        = 4'h8;
    i_timeout_enable = 1'b0;
    i_timeout_cycle  = '0;
    i_cmd_valid      = 1'b0;
    i_cmd            = '0;
    i_resp_accept    = 1'b1;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    refresh_head();
    fork
      drive_backpressure();
    join_none
    repeat (5) @(negedge i_clk);
    i_rst_n = 1'b1;

    order_test();
    if (!aborted) read_data_test();
    if (!aborted) posted_test();
    if (!aborted) unmapped_test();
    if (!aborted) backpressure_test();
    // Leaves one slot stuck, so it runs last
    if (!aborted) timeout_test();

    $display("Summary: %0d commands, %0d responses checked, %0d failures",
             cmd_count, resp_count, fail_count);
    if (fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- sim.f
rtl/csr_bus_pkg.sv
rtl/csr_map_pkg.sv
rtl/csr_slice.sv
rtl/csr_response_reorder.sv
rtl/csr_target_bank.sv
rtl/csr_reorder_top.sv
testbench/tb_csr_reorder.sv
